// File: dcache_top.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_plru.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tests/dcache_checker.sv
tests/tb_dcache_top.sv

// File: run_sim.sh
#!/bin/sh
# build the cache testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_dcache

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f dcache_top.f --top-module tb_dcache_top -Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./$BIN > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "simulation log has no final result"
	exit 1
fi
exit 0

// File: tests/tb_dcache_top.sv
// testbench top for the data cache, drives request sequences and models the backing memory
`include "dcache_cfg.svh"

module tb_dcache_top
	import dcache_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// 5 + 3 + 3 + 12 + 200 requests over the five tests
	localparam int N_REQ = 223;
	localparam word_t INIT_XOR = 32'h5ac3_96e1;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_ready;
	cpu_req_t req;
	logic resp_valid;
	word_t resp_rdata;
	logic mem_rd_valid;
	logic mem_rd_ready;
	mem_rd_req_t mem_rd_addr;
	logic mem_rd_data_valid;
	line_t mem_rd_data;
	logic mem_wr_valid;
	logic mem_wr_ready;
	mem_wr_req_t mem_wr;
	logic hit_exp;
	int test_id;
	logic test_done;
	int checks;
	int errors;
	int pending;
	int seed = 32'hbebf;
	word_t mem_q [addr_t];

	dcache_top dcache_top_inst (
		.clk, .rst,
		.req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
		.resp_valid_o(resp_valid), .resp_rdata_o(resp_rdata),
		.mem_rd_valid_o(mem_rd_valid), .mem_rd_ready_i(mem_rd_ready),
		.mem_rd_addr_o(mem_rd_addr), .mem_rd_data_valid_i(mem_rd_data_valid),
		.mem_rd_data_i(mem_rd_data),
		.mem_wr_valid_o(mem_wr_valid), .mem_wr_ready_i(mem_wr_ready), .mem_wr_o(mem_wr)
	);

	dcache_checker #(.INIT_XOR(INIT_XOR)) dcache_checker_inst (
		.clk, .rst,
		.req_valid_i(req_valid), .req_ready_i(req_ready), .req_i(req), .hit_exp_i(hit_exp),
		.resp_valid_i(resp_valid), .resp_rdata_i(resp_rdata),
		.mem_rd_valid_i(mem_rd_valid), .mem_wr_valid_i(mem_wr_valid),
		.test_id_i(test_id), .test_done_i(test_done),
		.checks_o(checks), .errors_o(errors), .pending_o(pending)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// untouched words hold their address xor a constant
	function automatic word_t mem_word(addr_t a);
		return mem_q.exists(a) ? mem_q[a] : (a ^ INIT_XOR);
	endfunction

	function automatic line_t read_line(addr_t base);
		line_t line;
		for (int i = 0; i < `DC_LINE_WORDS; i++) begin
			line[i*`DC_WORD_W +: `DC_WORD_W] = mem_word(base + addr_t'(4 * i));
		end
		return line;
	endfunction

	function automatic void write_line(addr_t base, line_t line);
		for (int i = 0; i < `DC_LINE_WORDS; i++) begin
			mem_q[base + addr_t'(4 * i)] = line[i*`DC_WORD_W +: `DC_WORD_W];
		end
	endfunction

	// six tags that all fall into set 9
	function automatic addr_t set_addr(int k);
		return {18'h0, 3'(k), 6'd9, 3'(k), 2'b00};
	endfunction

	task automatic send_req(input addr_t addr, input logic write, input word_t wdata,
		input be_t be, input logic exp_hit);
		req = '{addr: addr, write: write, wdata: wdata, be: be};
		hit_exp = exp_hit;
		req_valid = 1'b1;
		@(posedge clk);
		while (!req_ready)
			@(posedge clk);
		#1;
		req_valid = 1'b0;
		hit_exp = 1'b0;
	endtask

	task automatic finish_test(input int id);
		do begin
			@(posedge clk);
			#1;
		end while (pending != 0);
		test_id = id;
		test_done = 1'b1;
		@(posedge clk);
		#1;
		test_done = 1'b0;
	endtask

	// memory with random ready and random read return delay
	initial begin : memory_model
		addr_t rd_addr;
		int rd_wait;
		logic rd_busy;
		rd_addr = '0;
		rd_wait = 0;
		rd_busy = 1'b0;
		mem_rd_ready = 1'b0;
		mem_wr_ready = 1'b0;
		mem_rd_data_valid = 1'b0;
		mem_rd_data = '0;
		forever begin
			@(posedge clk);
			if (mem_wr_valid && mem_wr_ready)
				write_line(mem_wr.addr, mem_wr.data);
			if (mem_rd_valid && mem_rd_ready) begin
				rd_busy = 1'b1;
				rd_addr = mem_rd_addr;
				rd_wait = int'($unsigned($random(seed)) % 6);
			end
			#1;
			mem_rd_data_valid = 1'b0;
			if (rd_busy && rd_wait == 0) begin
				mem_rd_data_valid = 1'b1;
				mem_rd_data = read_line(rd_addr);
				rd_busy = 1'b0;
			end else if (rd_busy) begin
				rd_wait--;
			end
			mem_rd_ready = ($random(seed) & 3) != 0;
			mem_wr_ready = ($random(seed) & 3) != 0;
		end
	end

	initial begin : watchdog
		repeat (N_REQ * 200) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", N_REQ * 200);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] r;
		addr_t a;
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		hit_exp = 1'b0;
		test_id = 0;
		test_done = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// first request already waits while the tags clear
		send_req(32'h0000_0100, 1'b0, '0, '0, 1'b0);
		send_req(32'h1234_5678, 1'b0, '0, '0, 1'b0);
		send_req(32'hdead_bee0, 1'b0, '0, '0, 1'b0);
		send_req(32'h8000_0004, 1'b0, '0, '0, 1'b0);
		send_req(32'h0000_7ffc, 1'b0, '0, '0, 1'b0);
		finish_test(1);

		send_req(32'h0000_2040, 1'b1, 32'h1357_9bdf, 4'hf, 1'b0);
		send_req(32'h0000_2040, 1'b0, '0, '0, 1'b0);
		send_req(32'h0000_2040, 1'b0, '0, '0, 1'b1);
		finish_test(2);

		send_req(32'h0000_3004, 1'b1, 32'ha1b2_c3d4, 4'b0101, 1'b0);
		send_req(32'h0000_3004, 1'b1, 32'h1122_3344, 4'b1000, 1'b0);
		send_req(32'h0000_3004, 1'b0, '0, '0, 1'b0);
		finish_test(3);

		// more dirty lines than ways in one set
		for (int k = 1; k <= 6; k++) begin
			send_req(set_addr(k), 1'b1, word_t'(32'hc0de_0000 + k), 4'hf, 1'b0);
		end
		for (int k = 1; k <= 6; k++) begin
			send_req(set_addr(k), 1'b0, '0, '0, 1'b0);
		end
		finish_test(4);

		// 8 tags over 2 sets keep hits and evictions frequent
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			a = {18'h0_0a5, r[2:0], 5'd3, r[3], r[6:4], 2'b00};
			send_req(a, r[7], $random(seed), r[11:8], 1'b0);
			repeat (r[13:12]) begin
				@(posedge clk);
				#1;
			end
		end
		finish_test(5);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: tests/dcache_checker.sv
// scoreboard for the cache testbench, predicts every response from a shadow memory and counts errors
`include "dcache_cfg.svh"

module dcache_checker
	import dcache_pkg::*;
#(
	parameter word_t INIT_XOR = '0,
	parameter int unsigned RESP_LIMIT = 200
) (
	input logic clk,
	input logic rst,
	input logic req_valid_i,
	input logic req_ready_i,
	input cpu_req_t req_i,
	input logic hit_exp_i,
	input logic resp_valid_i,
	input word_t resp_rdata_i,
	input logic mem_rd_valid_i,
	input logic mem_wr_valid_i,
	input int test_id_i,
	input logic test_done_i,
	output int checks_o,
	output int errors_o,
	output int pending_o
);

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		addr_t addr;
		logic hit;
		word_t data;
		int unsigned cycle;
	} pending_t;

	pending_t pend_q [$];
	word_t shadow_q [addr_t];
	int unsigned cycle = 0;
	int unsigned clear_cnt = 0;
	logic stall_seen = 1'b0;
	int checks = 0;
	int errors = 0;
	int pending = 0;
	int test_checks = 0;
	int test_errors = 0;

	assign checks_o = checks;
	assign errors_o = errors;
	assign pending_o = pending;

	// expected word after the request, stores merge their enabled bytes
	function automatic word_t expect_word(cpu_req_t r);
		addr_t a;
		word_t w;
		a = {r.addr[`DC_ADDR_W-1:2], 2'b00};
		w = shadow_q.exists(a) ? shadow_q[a] : (a ^ INIT_XOR);
		if (r.write) begin
			for (int b = 0; b < 4; b++) begin
				if (r.be[b])
					w[8*b +: 8] = r.wdata[8*b +: 8];
			end
		end
		return w;
	endfunction

	always @(posedge clk) begin : monitor
		pending_t p;
		// cache must stay silent while the tags clear
		if (rst) begin
			clear_cnt = 0;
		end else if (clear_cnt < `DC_SETS) begin
			if (req_ready_i || resp_valid_i || mem_rd_valid_i || mem_wr_valid_i) begin
				$display("MISMATCH %0d ns: cache output high in clear cycle %0d",
					$time, clear_cnt);
				errors++;
			end
			clear_cnt++;
			if (clear_cnt == `DC_SETS)
				checks++;
		end
		if (resp_valid_i) begin
			if (pending == 0) begin
				$display("response at %0d ns with no request outstanding", $time);
				errors++;
			end else begin
				p = pend_q.pop_front();
				pending--;
				stall_seen = 1'b0;
				checks++;
				if (resp_rdata_i !== p.data) begin
					$display("MISMATCH %0d ns: address 0x%08h returned 0x%08h, expected 0x%08h",
						$time, p.addr, resp_rdata_i, p.data);
					errors++;
				end
				if (p.hit && cycle != p.cycle + 2) begin
					$display("MISMATCH %0d ns: hit at 0x%08h answered after %0d cycles, expected 2",
						$time, p.addr, cycle - p.cycle);
					errors++;
				end
			end
		end
		if (req_valid_i && req_ready_i) begin
			p.addr = req_i.addr;
			p.hit = hit_exp_i;
			p.data = expect_word(req_i);
			p.cycle = cycle;
			if (req_i.write)
				shadow_q[{req_i.addr[`DC_ADDR_W-1:2], 2'b00}] = p.data;
			pend_q.push_back(p);
			pending++;
		end
		if (pending != 0 && !stall_seen && cycle - pend_q[0].cycle > RESP_LIMIT) begin
			$display("no response to the request at 0x%08h within %0d cycles",
				pend_q[0].addr, RESP_LIMIT);
			errors++;
			stall_seen = 1'b1;
		end
		if (test_done_i) begin
			$display("test %0d done: %0d checks, %0d errors", test_id_i,
				checks - test_checks, errors - test_errors);
			test_checks = checks;
			test_errors = errors;
		end
		cycle++;
	end

endmodule

// File: hdl/dcache_top.sv
// data cache top, connects the FSM, tag store, data store and PLRU to the cpu and memory ports
`include "dcache_cfg.svh"

module dcache_top
	import dcache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req_valid_i,
	output logic req_ready_o,
	input cpu_req_t req_i,
	output logic resp_valid_o,
	output word_t resp_rdata_o,
	output logic mem_rd_valid_o,
	input logic mem_rd_ready_i,
	output mem_rd_req_t mem_rd_addr_o,
	input logic mem_rd_data_valid_i,
	input line_t mem_rd_data_i,
	output logic mem_wr_valid_o,
	input logic mem_wr_ready_i,
	output mem_wr_req_t mem_wr_o
);

	index_t set_index;
	tag_t lookup_tag;
	logic [`DC_WAYS-1:0] tag_hit;
	way_t tag_hit_way;
	tag_entry_t [`DC_WAYS-1:0] tag_entries;
	logic [`DC_WAYS-1:0] tag_we;
	index_t tag_w_index;
	tag_entry_t tag_w_entry;
	way_t data_rd_way;
	line_t rd_line;
	logic data_word_we;
	logic data_fill_we;
	way_t data_w_way;
	offset_t data_w_offset;
	word_t data_w_word;
	be_t data_w_be;
	line_t data_fill_line;
	logic plru_access;
	way_t plru_access_way;
	logic [`DC_WAYS-1:0] plru_valid;
	way_t plru_victim;

	dcache_ctrl dcache_ctrl_inst (
		.clk, .rst,
		.req_valid_i, .req_ready_o, .req_i, .resp_valid_o, .resp_rdata_o,
		.mem_rd_valid_o, .mem_rd_ready_i, .mem_rd_addr_o,
		.mem_rd_data_valid_i, .mem_rd_data_i,
		.mem_wr_valid_o, .mem_wr_ready_i, .mem_wr_o,
		.set_index_o(set_index), .lookup_tag_o(lookup_tag),
		.tag_hit_i(tag_hit), .tag_hit_way_i(tag_hit_way), .tag_entries_i(tag_entries),
		.tag_we_o(tag_we), .tag_w_index_o(tag_w_index), .tag_w_entry_o(tag_w_entry),
		.data_rd_way_o(data_rd_way), .data_word_we_o(data_word_we),
		.data_fill_we_o(data_fill_we), .data_w_way_o(data_w_way),
		.data_w_offset_o(data_w_offset), .data_w_word_o(data_w_word),
		.data_w_be_o(data_w_be), .data_fill_line_o(data_fill_line),
		.rd_line_i(rd_line),
		.plru_access_o(plru_access), .plru_access_way_o(plru_access_way),
		.plru_valid_o(plru_valid), .plru_victim_i(plru_victim)
	);

	dcache_tag_store dcache_tag_store_inst (
		.clk, .rst,
		.lookup_index_i(set_index), .lookup_tag_i(lookup_tag),
		.hit_o(tag_hit), .hit_way_o(tag_hit_way), .entries_o(tag_entries),
		.we_i(tag_we), .w_index_i(tag_w_index), .w_entry_i(tag_w_entry)
	);

	// data writes always target the set of the request in flight
	dcache_data_store dcache_data_store_inst (
		.clk,
		.rd_index_i(set_index), .rd_way_i(data_rd_way), .rd_line_o(rd_line),
		.word_we_i(data_word_we), .fill_we_i(data_fill_we),
		.w_index_i(set_index), .w_way_i(data_w_way), .w_offset_i(data_w_offset),
		.w_word_i(data_w_word), .w_be_i(data_w_be), .fill_line_i(data_fill_line)
	);

	dcache_plru dcache_plru_inst (
		.clk, .rst,
		.index_i(set_index), .access_i(plru_access), .access_way_i(plru_access_way),
		.valid_i(plru_valid), .victim_o(plru_victim)
	);

endmodule

// File: hdl/dcache_ctrl.sv
// request and miss FSM of the cache, drives the tag, data and PLRU blocks and the memory ports
`include "dcache_cfg.svh"

module dcache_ctrl
	import dcache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req_valid_i,
	output logic req_ready_o,
	input cpu_req_t req_i,
	output logic resp_valid_o,
	output word_t resp_rdata_o,
	output logic mem_rd_valid_o,
	input logic mem_rd_ready_i,
	output mem_rd_req_t mem_rd_addr_o,
	input logic mem_rd_data_valid_i,
	input line_t mem_rd_data_i,
	output logic mem_wr_valid_o,
	input logic mem_wr_ready_i,
	output mem_wr_req_t mem_wr_o,
	output index_t set_index_o,
	output tag_t lookup_tag_o,
	input logic [`DC_WAYS-1:0] tag_hit_i,
	input way_t tag_hit_way_i,
	input tag_entry_t [`DC_WAYS-1:0] tag_entries_i,
	output logic [`DC_WAYS-1:0] tag_we_o,
	output index_t tag_w_index_o,
	output tag_entry_t tag_w_entry_o,
	output way_t data_rd_way_o,
	output logic data_word_we_o,
	output logic data_fill_we_o,
	output way_t data_w_way_o,
	output offset_t data_w_offset_o,
	output word_t data_w_word_o,
	output be_t data_w_be_o,
	output line_t data_fill_line_o,
	input line_t rd_line_i,
	output logic plru_access_o,
	output way_t plru_access_way_o,
	output logic [`DC_WAYS-1:0] plru_valid_o,
	input way_t plru_victim_i
);

	ctrl_state_t state_q, state_d;
	index_t clr_cnt_q;
	cpu_req_t req_q;
	way_t victim_q;
	tag_t victim_tag_q;
	logic lookup_hit;
	tag_entry_t victim_entry;
	tag_t req_tag;
	word_t rd_word;

	assign set_index_o = addr_index(req_q.addr);
	assign req_tag = addr_tag(req_q.addr);
	assign lookup_tag_o = req_tag;
	assign lookup_hit = |tag_hit_i;
	assign victim_entry = tag_entries_i[plru_victim_i];

	always_comb begin
		state_d = state_q;
		case (state_q)
			CLEAR: if (&clr_cnt_q) state_d = IDLE;
			IDLE: if (req_valid_i) state_d = LOOKUP;
			LOOKUP: begin
				if (lookup_hit)
					state_d = RESPOND;
				else if (victim_entry.valid && victim_entry.dirty)
					state_d = WRITEBACK;
				else
					state_d = REFILL_REQ;
			end
			WRITEBACK: if (mem_wr_ready_i) state_d = REFILL_REQ;
			REFILL_REQ: if (mem_rd_ready_i) state_d = REFILL_WAIT;
			// after the fill the same request is looked up again and hits
			REFILL_WAIT: if (mem_rd_data_valid_i) state_d = LOOKUP;
			RESPOND: state_d = IDLE;
			default: state_d = CLEAR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= CLEAR;
			clr_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == CLEAR)
				clr_cnt_q <= clr_cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid_i && req_ready_o)
			req_q <= req_i;
		if (state_q == LOOKUP && !lookup_hit) begin
			victim_q <= plru_victim_i;
			victim_tag_q <= victim_entry.tag;
		end
	end

	assign req_ready_o = (state_q == IDLE);

	// registered line holds the pre-store word, merge it here
	assign rd_word = get_word(rd_line_i, addr_offset(req_q.addr));
	assign resp_valid_o = (state_q == RESPOND);
	assign resp_rdata_o = req_q.write ? merge_word(rd_word, req_q.wdata, req_q.be) : rd_word;

	assign mem_rd_valid_o = (state_q == REFILL_REQ);
	assign mem_rd_addr_o = line_addr(req_tag, set_index_o);
	assign mem_wr_valid_o = (state_q == WRITEBACK);
	assign mem_wr_o.addr = line_addr(victim_tag_q, set_index_o);
	assign mem_wr_o.data = rd_line_i;

	always_comb begin
		tag_we_o = '0;
		tag_w_index_o = set_index_o;
		tag_w_entry_o = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
		case (state_q)
			CLEAR: begin
				tag_we_o = '1;
				tag_w_index_o = clr_cnt_q;
				tag_w_entry_o = '0;
			end
			LOOKUP: begin
				if (lookup_hit && req_q.write)
					tag_we_o = tag_hit_i;
			end
			REFILL_WAIT: begin
				if (mem_rd_data_valid_i)
					tag_we_o[victim_q] = 1'b1;
				tag_w_entry_o.dirty = 1'b0;
			end
			default: tag_we_o = '0;
		endcase
	end

	// on a miss the victim line is read so it is ready for write-back
	assign data_rd_way_o = (state_q != LOOKUP) ? victim_q :
		(lookup_hit ? tag_hit_way_i : plru_victim_i);
	assign data_word_we_o = (state_q == LOOKUP) && lookup_hit && req_q.write;
	assign data_fill_we_o = (state_q == REFILL_WAIT) && mem_rd_data_valid_i;
	assign data_w_way_o = (state_q == LOOKUP) ? tag_hit_way_i : victim_q;
	assign data_w_offset_o = addr_offset(req_q.addr);
	assign data_w_word_o = req_q.wdata;
	assign data_w_be_o = req_q.be;
	assign data_fill_line_o = mem_rd_data_i;

	assign plru_access_o = (state_q == LOOKUP) && lookup_hit;
	assign plru_access_way_o = tag_hit_way_i;
	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			plru_valid_o[w] = tag_entries_i[w].valid;
		end
	end

	rd_stable_a: assert property (@(posedge clk) disable iff (rst)
		mem_rd_valid_o && !mem_rd_ready_i |=> mem_rd_valid_o && $stable(mem_rd_addr_o))
		else $error("memory read request changed before ready");

	// write data comes from the data store, which must not change during write-back
	wr_stable_a: assert property (@(posedge clk) disable iff (rst)
		mem_wr_valid_o && !mem_wr_ready_i |=> mem_wr_valid_o && $stable(mem_wr_o))
		else $error("memory write request changed before ready");

endmodule

// File: hdl/dcache_plru.sv
// tree pseudo-LRU state per set with invalid-way preference, picks the refill victim
`include "dcache_cfg.svh"

module dcache_plru
	import dcache_pkg::*;
(
	input logic clk,
	input logic rst,
	input index_t index_i,
	input logic access_i,
	input way_t access_way_i,
	input logic [`DC_WAYS-1:0] valid_i,
	output way_t victim_o
);

	// bit 0 picks the half, bit 1 ways 0/1, bit 2 ways 2/3
	logic [2:0] tree_q [`DC_SETS];
	logic [2:0] tree;
	way_t tree_way;

	assign tree = tree_q[index_i];
	assign tree_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

	// lowest invalid way wins over the tree
	always_comb begin
		victim_o = tree_way;
		for (int w = `DC_WAYS - 1; w >= 0; w--) begin
			if (!valid_i[w])
				victim_o = way_t'(w);
		end
	end

	// point every bit on the path away from the accessed way
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				tree_q[s] <= '0;
			end
		end else if (access_i) begin
			tree_q[index_i][0] <= ~access_way_i[1];
			if (access_way_i[1])
				tree_q[index_i][2] <= ~access_way_i[0];
			else
				tree_q[index_i][1] <= ~access_way_i[0];
		end
	end

endmodule

// File: hdl/dcache_data_store.sv
// line arrays for all ways with registered read, byte-merged word write and line fill
`include "dcache_cfg.svh"

module dcache_data_store
	import dcache_pkg::*;
(
	input logic clk,
	input index_t rd_index_i,
	input way_t rd_way_i,
	output line_t rd_line_o,
	input logic word_we_i,
	input logic fill_we_i,
	input index_t w_index_i,
	input way_t w_way_i,
	input offset_t w_offset_i,
	input word_t w_word_i,
	input be_t w_be_i,
	input line_t fill_line_i
);

	line_t line_q [`DC_WAYS][`DC_SETS];
	word_t merged_word;

	// old word with the enabled store bytes replaced
	assign merged_word = merge_word(get_word(line_q[w_way_i][w_index_i], w_offset_i),
		w_word_i, w_be_i);

	// read sees the array before this edge's write
	always_ff @(posedge clk) begin
		rd_line_o <= line_q[rd_way_i][rd_index_i];
	end

	always_ff @(posedge clk) begin
		if (fill_we_i)
			line_q[w_way_i][w_index_i] <= fill_line_i;
		else if (word_we_i)
			line_q[w_way_i][w_index_i][w_offset_i*`DC_WORD_W +: `DC_WORD_W] <= merged_word;
	end

	// store hits and refills come from different controller states
	no_dual_write_a: assert property (@(posedge clk)
		!(word_we_i && fill_we_i))
		else $error("word write and line fill in the same cycle");

endmodule

// File: hdl/dcache_tag_store.sv
// valid, dirty and tag arrays for all ways with the per-way hit compare, used by the cache top
`include "dcache_cfg.svh"

module dcache_tag_store
	import dcache_pkg::*;
(
	input logic clk,
	input logic rst,
	input index_t lookup_index_i,
	input tag_t lookup_tag_i,
	output logic [`DC_WAYS-1:0] hit_o,
	output way_t hit_way_o,
	output tag_entry_t [`DC_WAYS-1:0] entries_o,
	input logic [`DC_WAYS-1:0] we_i,
	input index_t w_index_i,
	input tag_entry_t w_entry_i
);

	tag_entry_t entry_q [`DC_WAYS][`DC_SETS];

	// one write port shared by all ways, same index
	always_ff @(posedge clk) begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (we_i[w])
				entry_q[w][w_index_i] <= w_entry_i;
		end
	end

	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			entries_o[w] = entry_q[w][lookup_index_i];
		end
	end

	always_comb begin
		hit_way_o = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			hit_o[w] = entries_o[w].valid && (entries_o[w].tag == lookup_tag_i);
			if (hit_o[w])
				hit_way_o = way_t'(w);
		end
	end

	// a line lives in one way only, refill never duplicates a tag in a set
	single_hit_a: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(hit_o) |-> $onehot0(hit_o))
		else $error("more than one way hits in set %0d", lookup_index_i);

endmodule

// File: hdl/dcache_pkg.sv
// shared types and address helpers for the data cache, imported by every cache module
`include "dcache_cfg.svh"

package dcache_pkg;

	localparam int unsigned WORD_BYTES = `DC_WORD_W / 8;
	localparam int unsigned WORD_OFF_W = $clog2(WORD_BYTES);
	localparam int unsigned OFFSET_W = $clog2(`DC_LINE_WORDS);
	localparam int unsigned LINE_OFF_W = OFFSET_W + WORD_OFF_W;
	localparam int unsigned INDEX_W = $clog2(`DC_SETS);
	localparam int unsigned TAG_W = `DC_ADDR_W - INDEX_W - LINE_OFF_W;
	localparam int unsigned WAY_W = $clog2(`DC_WAYS);
	localparam int unsigned LINE_W = `DC_LINE_WORDS * `DC_WORD_W;

	typedef logic [`DC_ADDR_W-1:0] addr_t;
	typedef logic [`DC_WORD_W-1:0] word_t;
	typedef logic [WORD_BYTES-1:0] be_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [WAY_W-1:0] way_t;
	typedef logic [LINE_W-1:0] line_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} tag_entry_t;

	typedef struct packed {
		addr_t addr;
		logic write;
		word_t wdata;
		be_t be;
	} cpu_req_t;

	// line aligned, low offset bits are zero
	typedef addr_t mem_rd_req_t;

	typedef struct packed {
		addr_t addr;
		line_t data;
	} mem_wr_req_t;

	typedef enum logic [2:0] {
		CLEAR,
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL_REQ,
		REFILL_WAIT,
		RESPOND
	} ctrl_state_t;

	function automatic tag_t addr_tag(addr_t addr);
		return addr[`DC_ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t addr);
		return addr[LINE_OFF_W +: INDEX_W];
	endfunction

	function automatic offset_t addr_offset(addr_t addr);
		return addr[WORD_OFF_W +: OFFSET_W];
	endfunction

	function automatic addr_t line_addr(tag_t tag, index_t index);
		return {tag, index, {LINE_OFF_W{1'b0}}};
	endfunction

	function automatic word_t get_word(line_t line, offset_t offset);
		return line[offset*`DC_WORD_W +: `DC_WORD_W];
	endfunction

	// bytes with be set come from new_word
	function automatic word_t merge_word(word_t old_word, word_t new_word, be_t be);
		word_t res;
		res = old_word;
		for (int b = 0; b < WORD_BYTES; b++) begin
			if (be[b])
				res[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return res;
	endfunction

endpackage

// File: hdl/dcache_cfg.svh
// cache geometry and width macros, included by the package and any file that sizes ports
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address and cpu word widths
`define DC_ADDR_W 32
`define DC_WORD_W 32

// words per line
`define DC_LINE_WORDS 8

// associativity and number of sets
`define DC_WAYS 4
`define DC_SETS 64

`endif
